// ==== include/gb_io_params.svh ====
// Fixed widths and constants of the console I/O register block.
// Include this header wherever a width or a divider tap position is needed.

`ifndef GB_IO_PARAMS_SVH
`define GB_IO_PARAMS_SVH

`define GB_DATA_W 8   // Register data width.
`define GB_ADDR_W 8   // Offset of a register within the I/O page.
`define GB_NUM_IRQ 5  // Interrupt sources held in IF and IE.
`define GB_DIV_W 16   // Divider counter width; DIV is its top byte.

// Divider bits that clock TIMA for each TAC rate selection.
`define GB_TAP_1024 9
`define GB_TAP_16 3
`define GB_TAP_64 5
`define GB_TAP_256 7

`endif

// ==== rtl/gb_bus_pkg.sv ====
// Types of the CPU-side register bus.
// The request travels with req and the response with ack in a four-phase handshake.

`default_nettype none

`include "gb_io_params.svh"

package gb_bus_pkg;

	typedef enum logic {
		BUS_READ,
		BUS_WRITE
	} bus_op_e;

	typedef struct packed {
		bus_op_e op;                  // Held stable while req is high.
		logic [`GB_ADDR_W-1:0] addr;
		logic [`GB_DATA_W-1:0] wdata; // Ignored on reads.
	} bus_req_t;

	typedef struct packed {
		logic [`GB_DATA_W-1:0] rdata; // Valid while ack is high.
		logic valid;                  // Low when no register answers the address.
	} bus_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/gb_io_pkg.sv ====
// Types of the I/O register block: register map, decoded write, joypad
// buttons and interrupt flag positions. Used by the bus controller and
// by each event block to pick out its own registers.

`default_nettype none

`include "gb_io_params.svh"

package gb_io_pkg;

	// Enum values are the register offsets within the I/O page.
	typedef enum logic [`GB_ADDR_W-1:0] {
		REG_P1   = 8'h00,
		REG_NONE = 8'h01, // The serial data offset, which nothing answers here.
		REG_DIV  = 8'h04,
		REG_TIMA = 8'h05,
		REG_TMA  = 8'h06,
		REG_TAC  = 8'h07,
		REG_IF   = 8'h0F,
		REG_STAT = 8'h41,
		REG_LY   = 8'h44,
		REG_LYC  = 8'h45,
		REG_IE   = 8'hFF
	} io_reg_e;

	typedef struct packed {
		logic strobe;                // High for one cycle per bus write.
		io_reg_e id;
		logic [`GB_DATA_W-1:0] data;
	} io_wr_t;

	// All buttons read 0 while pressed.
	typedef struct packed {
		logic right;
		logic left;
		logic up;
		logic down;
		logic a;
		logic b;
		logic select;
		logic start;
	} buttons_t;

	typedef enum logic [2:0] {
		IRQ_VBLANK   = 3'd0,
		IRQ_LCD_STAT = 3'd1,
		IRQ_TIMER    = 3'd2,
		IRQ_SERIAL   = 3'd3,
		IRQ_JOYPAD   = 3'd4
	} irq_bit_e;

endpackage

`default_nettype wire

// ==== rtl/io_bus_ctrl.sv ====
// Register bus slave of the I/O block. Runs the req/ack handshake, decodes
// the offset, sends one write strobe per write to the event blocks, and
// holds the interrupt flag and enable registers that drive irq.

`default_nettype none

`include "gb_io_params.svh"

module io_bus_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic req,
	input  gb_bus_pkg::bus_req_t bus_req,
	output logic ack,
	output gb_bus_pkg::bus_rsp_t bus_rsp,
	output gb_io_pkg::io_wr_t wr,
	input  logic [3:0][`GB_DATA_W-1:0] timer_rd, // DIV, TIMA, TMA, TAC from index 0 up.
	input  logic [`GB_DATA_W-1:0] joy_rd,
	input  logic [`GB_DATA_W-1:0] stat_rd,
	input  logic [`GB_DATA_W-1:0] lyc_rd,
	input  logic timer_evt,
	input  logic joypad_evt,
	input  logic vblank_evt,
	input  logic stat_evt,
	input  logic [`GB_DATA_W-1:0] ly,
	output logic irq
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACK,
		ST_WAIT_REL
	} state_e;

	state_e state_q, state_d;
	gb_io_pkg::io_reg_e reg_id;
	logic access;
	logic [`GB_DATA_W-1:0] rd_data;
	logic [`GB_NUM_IRQ-1:0] if_q, if_d, ie_q, evt_vec;

	function automatic gb_io_pkg::io_reg_e decode(input logic [`GB_ADDR_W-1:0] addr);
		gb_io_pkg::io_reg_e id;
		id = gb_io_pkg::io_reg_e'(addr);
		case (id)
			gb_io_pkg::REG_P1, gb_io_pkg::REG_DIV, gb_io_pkg::REG_TIMA,
			gb_io_pkg::REG_TMA, gb_io_pkg::REG_TAC, gb_io_pkg::REG_IF,
			gb_io_pkg::REG_STAT, gb_io_pkg::REG_LY, gb_io_pkg::REG_LYC,
			gb_io_pkg::REG_IE: return id;
			default: return gb_io_pkg::REG_NONE;
		endcase
	endfunction

	assign reg_id = decode(bus_req.addr);
	assign access = (state_q == ST_IDLE) && req; // The access happens in the sampling cycle.
	assign ack = (state_q != ST_IDLE);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: if (req) state_d = ST_ACK;
			ST_ACK: state_d = req ? ST_WAIT_REL : ST_IDLE;
			ST_WAIT_REL: if (!req) state_d = ST_IDLE; // Ack holds as long as the master does.
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) state_q <= ST_IDLE;
		else state_q <= state_d;
	end

	assign wr.strobe = access && (bus_req.op == gb_bus_pkg::BUS_WRITE);
	assign wr.id = reg_id;
	assign wr.data = bus_req.wdata;

	always_comb begin
		case (reg_id)
			gb_io_pkg::REG_P1: rd_data = joy_rd;
			gb_io_pkg::REG_DIV, gb_io_pkg::REG_TIMA,
			gb_io_pkg::REG_TMA, gb_io_pkg::REG_TAC: rd_data = timer_rd[bus_req.addr[1:0]];
			gb_io_pkg::REG_IF: rd_data = {{(`GB_DATA_W - `GB_NUM_IRQ){1'b1}}, if_q};
			gb_io_pkg::REG_STAT: rd_data = stat_rd;
			gb_io_pkg::REG_LY: rd_data = ly;
			gb_io_pkg::REG_LYC: rd_data = lyc_rd;
			gb_io_pkg::REG_IE: rd_data = {{(`GB_DATA_W - `GB_NUM_IRQ){1'b0}}, ie_q};
			default: rd_data = '1; // Open bus.
		endcase
	end

	always_ff @(posedge clk) begin
		if (access) begin
			bus_rsp.rdata <= rd_data;
			bus_rsp.valid <= (reg_id != gb_io_pkg::REG_NONE);
		end
	end

	always_comb begin
		evt_vec = '0;
		evt_vec[gb_io_pkg::IRQ_VBLANK] = vblank_evt;
		evt_vec[gb_io_pkg::IRQ_LCD_STAT] = stat_evt;
		evt_vec[gb_io_pkg::IRQ_TIMER] = timer_evt;
		evt_vec[gb_io_pkg::IRQ_JOYPAD] = joypad_evt;
	end

	always_comb begin
		if_d = if_q;
		if (wr.strobe && wr.id == gb_io_pkg::REG_IF) if_d = wr.data[`GB_NUM_IRQ-1:0];
		if_d = if_d | evt_vec; // An event in the write cycle is not lost.
		if_d[gb_io_pkg::IRQ_SERIAL] = 1'b0; // No serial port in this block.
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			if_q <= '0;
			ie_q <= '0;
		end else begin
			if_q <= if_d;
			if (wr.strobe && wr.id == gb_io_pkg::REG_IE) ie_q <= wr.data[`GB_NUM_IRQ-1:0];
		end
	end

	assign irq = |(if_q & ie_q);

endmodule

`default_nettype wire

// ==== rtl/io_timer.sv ====
// Divider and programmable timer. DIV is the top byte of a free-running
// counter; TIMA steps on falling edges of the divider tap chosen by TAC
// and reloads from TMA when it wraps, raising the timer event.

`default_nettype none

`include "gb_io_params.svh"

module io_timer (
	input  logic clk,
	input  logic rst,
	input  gb_io_pkg::io_wr_t wr,
	output logic [`GB_DATA_W-1:0] rd_div,
	output logic [`GB_DATA_W-1:0] rd_tima,
	output logic [`GB_DATA_W-1:0] rd_tma,
	output logic [`GB_DATA_W-1:0] rd_tac,
	output logic timer_evt
);

	logic [`GB_DIV_W-1:0] div_q;
	logic [`GB_DATA_W-1:0] tima_q, tma_q;
	logic [2:0] tac_q;
	logic tap, tap_in, tap_q, tick, tima_wr;

	always_comb begin
		case (tac_q[1:0])
			2'b00: tap = div_q[`GB_TAP_1024];
			2'b01: tap = div_q[`GB_TAP_16];
			2'b10: tap = div_q[`GB_TAP_64];
			default: tap = div_q[`GB_TAP_256];
		endcase
	end

	assign tap_in = tap & tac_q[2];   // Disabling the timer gates the tap low.
	assign tick = tap_q & ~tap_in;    // Falling edge of the gated tap.
	assign tima_wr = wr.strobe && (wr.id == gb_io_pkg::REG_TIMA);
	assign timer_evt = tick && (tima_q == 8'hFF) && !tima_wr;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			div_q <= '0;
			tap_q <= 1'b0;
			tima_q <= '0;
			tma_q <= '0;
			tac_q <= '0;
		end else begin
			if (wr.strobe && wr.id == gb_io_pkg::REG_DIV) div_q <= '0; // Any value clears it.
			else div_q <= div_q + 1'b1;
			tap_q <= tap_in;
			if (tima_wr) tima_q <= wr.data;
			else if (tick) tima_q <= (tima_q == 8'hFF) ? tma_q : tima_q + 8'd1;
			if (wr.strobe && wr.id == gb_io_pkg::REG_TMA) tma_q <= wr.data;
			if (wr.strobe && wr.id == gb_io_pkg::REG_TAC) tac_q <= wr.data[2:0];
		end
	end

	assign rd_div = div_q[`GB_DIV_W-1 -: `GB_DATA_W];
	assign rd_tima = tima_q;
	assign rd_tma = tma_q;
	assign rd_tac = {5'b0, tac_q};

endmodule

`default_nettype wire

// ==== rtl/joypad_scan.sv ====
// Joypad register P1. The CPU selects the direction or action row through
// bits 5:4 and reads the matrix on the low nibble. A new press of any
// button raises the joypad event.

`default_nettype none

`include "gb_io_params.svh"

module joypad_scan (
	input  logic clk,
	input  logic rst,
	input  gb_io_pkg::io_wr_t wr,
	input  gb_io_pkg::buttons_t buttons,
	output logic [`GB_DATA_W-1:0] p1_rd,
	output logic joypad_evt
);

	logic [1:0] sel_q; // Bit 0 low picks directions, bit 1 low picks actions.
	gb_io_pkg::buttons_t btn_q;
	logic [3:0] dir_nib, act_nib, low_nib;

	assign dir_nib = {buttons.down, buttons.up, buttons.left, buttons.right};
	assign act_nib = {buttons.start, buttons.select, buttons.b, buttons.a};
	assign low_nib = (sel_q[0] ? 4'hF : dir_nib) & (sel_q[1] ? 4'hF : act_nib);
	assign p1_rd = {2'b11, sel_q, low_nib};

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			sel_q <= 2'b11;
			btn_q <= '1; // All released.
			joypad_evt <= 1'b0;
		end else begin
			if (wr.strobe && wr.id == gb_io_pkg::REG_P1) sel_q <= wr.data[5:4];
			btn_q <= buttons;
			joypad_evt <= |(btn_q & ~buttons); // High to low is a press.
		end
	end

endmodule

`default_nettype wire

// ==== rtl/lcd_stat_irq.sv ====
// LCD status and line compare. Registers the display mode and the LY/LYC
// match for STAT, and raises the vertical-blank event and the STAT event
// on mode entries and on a new coincidence, as enabled in STAT.

`default_nettype none

`include "gb_io_params.svh"

module lcd_stat_irq (
	input  logic clk,
	input  logic rst,
	input  gb_io_pkg::io_wr_t wr,
	input  logic [1:0] lcd_mode,
	input  logic [`GB_DATA_W-1:0] ly,
	output logic [`GB_DATA_W-1:0] stat_rd,
	output logic [`GB_DATA_W-1:0] lyc_rd,
	output logic vblank_evt,
	output logic stat_evt
);

	logic [3:0] stat_en_q; // STAT bits 6:3.
	logic [`GB_DATA_W-1:0] lyc_q;
	logic [1:0] mode_q;
	logic coin_q, coin_d, mode_entry, mode_hit, coin_hit;

	assign coin_d = (ly == lyc_q);
	assign mode_entry = (lcd_mode != mode_q);
	// Mode 3 has no enable bit.
	assign mode_hit = mode_entry && (lcd_mode != 2'd3) && stat_en_q[lcd_mode];
	assign coin_hit = stat_en_q[3] && coin_d && !coin_q;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			stat_en_q <= '0;
			lyc_q <= '0;
			mode_q <= 2'd0;
			coin_q <= 1'b0;
			vblank_evt <= 1'b0;
			stat_evt <= 1'b0;
		end else begin
			if (wr.strobe && wr.id == gb_io_pkg::REG_STAT) stat_en_q <= wr.data[6:3];
			if (wr.strobe && wr.id == gb_io_pkg::REG_LYC) lyc_q <= wr.data;
			mode_q <= lcd_mode;
			coin_q <= coin_d;
			vblank_evt <= mode_entry && (lcd_mode == 2'd1);
			stat_evt <= mode_hit || coin_hit;
		end
	end

	assign stat_rd = {1'b1, stat_en_q, coin_q, mode_q};
	assign lyc_rd = lyc_q;

endmodule

`default_nettype wire

// ==== rtl/gb_io_top.sv ====
// Memory-mapped I/O register block of the handheld console. The CPU reaches
// the joypad, timer, LCD status and interrupt registers over the req/ack bus;
// irq goes back to the CPU. Display mode and line come from the display engine.

`default_nettype none

`include "gb_io_params.svh"

module gb_io_top (
	input  logic clk,
	input  logic rst,
	input  logic req,
	input  gb_bus_pkg::bus_req_t bus_req,
	output logic ack,
	output gb_bus_pkg::bus_rsp_t bus_rsp,
	input  gb_io_pkg::buttons_t buttons,
	input  logic [1:0] lcd_mode,
	input  logic [`GB_DATA_W-1:0] ly,
	output logic irq
);

	gb_io_pkg::io_wr_t wr;
	logic [`GB_DATA_W-1:0] rd_div, rd_tima, rd_tma, rd_tac;
	logic [`GB_DATA_W-1:0] joy_rd, stat_rd, lyc_rd;
	logic timer_evt, joypad_evt, vblank_evt, stat_evt;

	io_bus_ctrl u_bus_ctrl (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.bus_req    (bus_req),
		.ack        (ack),
		.bus_rsp    (bus_rsp),
		.wr         (wr),
		.timer_rd   ({rd_tac, rd_tma, rd_tima, rd_div}), // Indexed by the low offset bits.
		.joy_rd     (joy_rd),
		.stat_rd    (stat_rd),
		.lyc_rd     (lyc_rd),
		.timer_evt  (timer_evt),
		.joypad_evt (joypad_evt),
		.vblank_evt (vblank_evt),
		.stat_evt   (stat_evt),
		.ly         (ly),
		.irq        (irq)
	);

	io_timer u_timer (
		.clk       (clk),
		.rst       (rst),
		.wr        (wr),
		.rd_div    (rd_div),
		.rd_tima   (rd_tima),
		.rd_tma    (rd_tma),
		.rd_tac    (rd_tac),
		.timer_evt (timer_evt)
	);

	joypad_scan u_joypad (
		.clk        (clk),
		.rst        (rst),
		.wr         (wr),
		.buttons    (buttons),
		.p1_rd      (joy_rd),
		.joypad_evt (joypad_evt)
	);

	lcd_stat_irq u_lcd_stat (
		.clk        (clk),
		.rst        (rst),
		.wr         (wr),
		.lcd_mode   (lcd_mode),
		.ly         (ly),
		.stat_rd    (stat_rd),
		.lyc_rd     (lyc_rd),
		.vblank_evt (vblank_evt),
		.stat_evt   (stat_evt)
	);

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
// Clock and reset source of the I/O block testbench.
// Makes a 100 ns clock and holds rst high for the first 10 rising edges.

`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam time HALF_PERIOD = 50ns;
	localparam int RESET_CYCLES = 10;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1ns rst = 1'b0; // Released just after an edge, like the other inputs.
	end

endmodule

`default_nettype wire

// ==== dv/gb_io_checker.sv ====
// Handshake and interrupt assertions for the I/O block.
// Bound into gb_io_top by the testbench; fail_count holds the number of failures.

`default_nettype none

`include "gb_io_params.svh"

module gb_io_checker (
	input logic clk,
	input logic rst,
	input logic req,
	input logic ack,
	input logic irq,
	input logic timer_evt,
	input logic joypad_evt,
	input logic [`GB_NUM_IRQ-1:0] if_q,
	input logic [`GB_NUM_IRQ-1:0] ie_q
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;

	a_ack_rise: assert property (@(posedge clk) disable iff (rst) req && !ack |=> ack)
		else begin
			$error("ack did not rise one cycle after req was sampled high");
			fail_count++;
		end

	a_ack_hold: assert property (@(posedge clk) disable iff (rst) req && ack |=> ack)
		else begin
			$error("ack fell while req was still held");
			fail_count++;
		end

	a_ack_fall: assert property (@(posedge clk) disable iff (rst) !req && ack |=> !ack)
		else begin
			$error("ack stayed high one cycle after req fell");
			fail_count++;
		end

	a_ack_idle: assert property (@(posedge clk) disable iff (rst) !req && !ack |=> !ack)
		else begin
			$error("ack rose without req");
			fail_count++;
		end

	// An enabled event reaches irq through IF in the very next cycle.
	a_irq_follow: assert property (@(posedge clk) disable iff (rst)
		(timer_evt && ie_q[2]) || (joypad_evt && ie_q[4]) |=> irq)
		else begin
			$error("irq did not rise one cycle after an enabled event");
			fail_count++;
		end

	// Events win over a write to IF in the same cycle.
	a_timer_flag: assert property (@(posedge clk) disable iff (rst) timer_evt |=> if_q[2])
		else begin
			$error("timer event did not set IF bit 2");
			fail_count++;
		end

	a_joypad_flag: assert property (@(posedge clk) disable iff (rst) joypad_evt |=> if_q[4])
		else begin
			$error("joypad event did not set IF bit 4");
			fail_count++;
		end

endmodule

`default_nettype wire

// ==== dv/gb_io_tb.sv ====
// Testbench of the console I/O register block. Drives the req/ack bus, the
// buttons and the display inputs through six tests, checks read values with
// immediate assertions and counts the failures of the bound checker.

`default_nettype none

`include "gb_io_params.svh"

module gb_io_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int BUS_TIMEOUT = 50;   // Cycles allowed for each handshake phase.
	localparam int NUM_ACCESSES = 120; // Upper bound of bus accesses over all tests.
	localparam int WAIT_CYCLES = 420;  // Idle cycles the tests spend between accesses.
	localparam int MARGIN = 200;
	localparam int WATCHDOG_CYCLES = 10 + NUM_ACCESSES * (2 * BUS_TIMEOUT + 2)
		+ WAIT_CYCLES + MARGIN;
	localparam int JOY_PATTERNS = 8;
	localparam int DIV_STEP = 256;     // One step of DIV.
	localparam time DRIVE_DELAY = 1ns;

	logic clk, rst, req, ack, irq;
	gb_bus_pkg::bus_req_t bus_req;
	gb_bus_pkg::bus_rsp_t bus_rsp;
	gb_io_pkg::buttons_t buttons;
	logic [1:0] lcd_mode;
	logic [`GB_DATA_W-1:0] ly;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_mark = 0;
	integer seed = 32'hcb2cc7dd;

	tb_clock_gen u_clk_gen (.clk(clk), .rst(rst));

	gb_io_top dut (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.bus_req  (bus_req),
		.ack      (ack),
		.bus_rsp  (bus_rsp),
		.buttons  (buttons),
		.lcd_mode (lcd_mode),
		.ly       (ly),
		.irq      (irq)
	);

	bind gb_io_top gb_io_checker u_checker (
		.clk(clk), .rst(rst), .req(req), .ack(ack), .irq(irq),
		.timer_evt(timer_evt), .joypad_evt(joypad_evt),
		.if_q(u_bus_ctrl.if_q), .ie_q(u_bus_ctrl.ie_q)
	);

	function automatic int failures();
		return errors + dut.u_checker.fail_count;
	endfunction

	// Low nibble of P1 from the button matrix; a row is read while its select bit is low.
	function automatic logic [3:0] matrix_nibble(input gb_io_pkg::buttons_t b,
		input logic [1:0] sel);
		logic [3:0] nib;
		nib = 4'hF;
		if (!sel[0]) nib &= {b.down, b.up, b.left, b.right};
		if (!sel[1]) nib &= {b.start, b.select, b.b, b.a};
		return nib;
	endfunction

	task automatic step_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
	endtask

	task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp)
		else begin
			$display("[FAIL] %0t: %s is %02h, expected %02h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_range(input string what, input logic [7:0] got,
		input logic [7:0] lo, input logic [7:0] hi);
		assert (got >= lo && got <= hi)
		else begin
			$display("[FAIL] %0t: %s is %02h, expected %02h to %02h", $time, what, got, lo, hi);
			errors++;
		end
	endtask

	// One complete four-phase handshake; hold keeps req up for extra cycles after ack.
	task automatic bus_access(input gb_bus_pkg::bus_op_e op, input logic [7:0] addr,
		input logic [7:0] wdata, input int hold, output logic [7:0] rdata, output logic valid);
		int waited;
		bus_req.op = op;
		bus_req.addr = addr;
		bus_req.wdata = wdata;
		req = 1'b1;
		waited = 0;
		do begin
			step_cycles(1);
			waited++;
		end while (!ack && waited < BUS_TIMEOUT);
		if (!ack) begin
			$display("%0t: no ack came within %0d cycles of req", $time, BUS_TIMEOUT);
			errors++;
		end
		rdata = bus_rsp.rdata; // Stable for as long as ack is high.
		valid = bus_rsp.valid;
		step_cycles(hold);
		req = 1'b0;
		waited = 0;
		do begin
			step_cycles(1);
			waited++;
		end while (ack && waited < BUS_TIMEOUT);
		if (ack) begin
			$display("%0t: ack stayed high after req was released", $time);
			errors++;
		end
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
		logic [7:0] rd;
		logic vld;
		bus_access(gb_bus_pkg::BUS_WRITE, addr, data, 0, rd, vld);
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
		logic vld;
		bus_access(gb_bus_pkg::BUS_READ, addr, 8'h00, 0, data, vld);
	endtask

	task automatic read_check(input logic [7:0] addr, input logic [7:0] exp, input string what);
		logic [7:0] rd;
		logic vld;
		bus_access(gb_bus_pkg::BUS_READ, addr, 8'h00, 0, rd, vld);
		check_value({what, " valid flag"}, vld, 8'h01);
		check_value(what, rd, exp);
	endtask

	task automatic finish_test(input string name);
		int now;
		now = failures();
		tests_run++;
		if (now == test_mark) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d failed checks", tests_run, name, now - test_mark);
		end
		test_mark = now;
	endtask

	initial begin
		logic [7:0] rd;
		logic vld;
		logic [7:0] rand_byte;
		gb_io_pkg::buttons_t pattern;
		int idx;
		req = 1'b0;
		bus_req = '0;
		buttons = '1; // All released.
		lcd_mode = 2'd0;
		ly = '0;
		wait (rst === 1'b0);
		step_cycles(1);

		check_value("ack after reset", ack, 8'h00);
		check_value("irq after reset", irq, 8'h00);
		read_check(gb_io_pkg::REG_IE, 8'h00, "IE after reset");
		read_check(gb_io_pkg::REG_TAC, 8'h00, "TAC after reset");
		read_check(gb_io_pkg::REG_IF, 8'hE0, "IF after reset");
		read_check(gb_io_pkg::REG_P1, 8'hFF, "P1 after reset");
		bus_access(gb_bus_pkg::BUS_READ, 8'h01, 8'h00, 0, rd, vld);
		check_value("unmapped read data", rd, 8'hFF);
		check_value("unmapped valid flag", vld, 8'h00);
		finish_test("reset values");

		bus_access(gb_bus_pkg::BUS_WRITE, gb_io_pkg::REG_IE, 8'h15, 4, rd, vld);
		bus_access(gb_bus_pkg::BUS_READ, gb_io_pkg::REG_IE, 8'h00, 2, rd, vld);
		check_value("IE after held write", rd, 8'h15);
		write_reg(gb_io_pkg::REG_IE, 8'h00);
		finish_test("handshake");

		write_reg(gb_io_pkg::REG_IF, 8'h00);
		write_reg(gb_io_pkg::REG_TMA, 8'h80);
		write_reg(gb_io_pkg::REG_TIMA, 8'hFE);
		write_reg(gb_io_pkg::REG_TAC, 8'h05); // Enabled, one step per 16 clocks.
		step_cycles(64);
		read_reg(gb_io_pkg::REG_IF, rd);
		check_value("IF timer bit", rd & 8'h04, 8'h04);
		read_reg(gb_io_pkg::REG_TIMA, rd);
		check_range("TIMA after reload", rd, 8'h80, 8'h83);
		write_reg(gb_io_pkg::REG_TAC, 8'h00);
		step_cycles(DIV_STEP); // DIV has left 00h by now.
		read_reg(gb_io_pkg::REG_DIV, rd);
		check_range("DIV before clear", rd, 8'h01, 8'hFF);
		write_reg(gb_io_pkg::REG_DIV, 8'h5A);
		read_check(gb_io_pkg::REG_DIV, 8'h00, "DIV after clear");
		finish_test("timer");

		for (int p = 0; p < JOY_PATTERNS; p++) begin
			rand_byte = $random(seed);
			pattern = rand_byte;
			buttons = pattern;
			for (int s = 0; s < 4; s++) begin
				write_reg(gb_io_pkg::REG_P1, {2'b00, s[1:0], 4'h0});
				read_check(gb_io_pkg::REG_P1, {2'b11, s[1:0], matrix_nibble(pattern, s[1:0])},
					"P1 matrix read");
			end
		end
		buttons = '1;
		step_cycles(3);
		write_reg(gb_io_pkg::REG_IF, 8'h00);
		idx = {$random(seed)} % 8;
		buttons = ~(8'h01 << idx);
		step_cycles(2); // Event one cycle after the press, IF one cycle later.
		read_reg(gb_io_pkg::REG_IF, rd);
		check_value("IF joypad bit after press", rd & 8'h10, 8'h10);
		buttons = '1;
		step_cycles(2);
		write_reg(gb_io_pkg::REG_P1, 8'h30);
		write_reg(gb_io_pkg::REG_IF, 8'h00);
		finish_test("joypad");

		write_reg(gb_io_pkg::REG_LYC, 8'd90);
		ly = 8'd90;
		step_cycles(1);
		read_check(gb_io_pkg::REG_LY, 8'd90, "LY read");
		read_reg(gb_io_pkg::REG_STAT, rd);
		check_value("STAT coincidence bit", rd & 8'h04, 8'h04);
		write_reg(gb_io_pkg::REG_STAT, 8'h10); // Interrupt on entry into mode 1.
		write_reg(gb_io_pkg::REG_IF, 8'h00);
		lcd_mode = 2'd1;
		step_cycles(2);
		read_check(gb_io_pkg::REG_IF, 8'hE3, "IF after entering vblank");
		finish_test("lcd status");

		write_reg(gb_io_pkg::REG_IE, 8'h1F);
		check_value("irq with IF and IE set", irq, 8'h01);
		write_reg(gb_io_pkg::REG_IF, 8'h00);
		check_value("irq after clearing IF", irq, 8'h00);
		buttons = 8'hFE; // Start pressed.
		step_cycles(2);
		check_value("irq after an enabled press", irq, 8'h01);
		buttons = '1;
		step_cycles(1);
		write_reg(gb_io_pkg::REG_IF, 8'h00);
		check_value("irq after clearing the press", irq, 8'h00);
		write_reg(gb_io_pkg::REG_IE, 8'h00);
		finish_test("interrupt line");

		$display("tests run: %0d, tests failed: %0d, failed checks: %0d",
			tests_run, tests_failed, failures());
		if (failures() == 0) $display("TEST PASSED");
		else $display("TEST FAILED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("the run timed out after %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== gb_io.f ====
+incdir+include
rtl/gb_bus_pkg.sv
rtl/gb_io_pkg.sv
rtl/io_bus_ctrl.sv
rtl/io_timer.sv
rtl/joypad_scan.sv
rtl/lcd_stat_irq.sv
rtl/gb_io_top.sv
dv/tb_clock_gen.sv
dv/gb_io_checker.sv
dv/gb_io_tb.sv
